// ==== design/env_pkg.sv ====
`default_nettype none

package env_pkg;

    typedef logic [8:0]  env_t;             // attenuation, 0 = loudest
    typedef logic [14:0] rate_acc_t;        // per-op rate accumulator
    typedef logic [2:0]  overflow_t;        // env step per sample
    typedef logic [5:0]  eff_rate_t;        // effective rate 0..63
    typedef logic [7:0]  ksl_add_t;         // key scale level attenuation
    typedef logic [4:0]  am_val_t;          // tremolo attenuation

    localparam env_t SILENCE = 9'd511;      // max attenuation

    typedef enum logic [1:0] {
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } env_state_t;

    localparam eff_rate_t ATTACK_INSTANT = 6'd60;   // attack jumps to 0 from here
    localparam eff_rate_t RATE_MAX       = 6'd63;   // cap on effective rate

    // tremolo triangle, counter top bits run 0..TREM_TOP
    localparam logic [5:0] TREM_TOP  = 6'd51;
    localparam logic [5:0] TREM_PEAK = 6'd26;

endpackage

`default_nettype wire

// ==== design/env_rate_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module env_rate_counter import op_reg_pkg::*, env_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            sample_clk_en,
    input  wire op_num_t   op_num,
    input  wire env_rate_t requested_rate,  // nibble picked by state
    input  wire            ksr,
    input  wire fnum_t     fnum,
    input  wire block_t    block,
    output overflow_t      rate_counter_overflow
);

    rate_acc_t   acc [NUM_OPS];             // one accumulator per op
    logic [3:0]  rof;                       // key scale offset
    logic [6:0]  rate_sum;                  // 4*rate + offset, up to 75
    eff_rate_t   eff_rate;
    logic [17:0] step;                      // (4 + low bits) << high bits
    logic [17:0] acc_sum;

    always_comb begin
        rof      = ksr ? {block, fnum[9]} : {3'b000, block[2]};
        rate_sum = {1'b0, requested_rate, 2'b00} + {3'b000, rof};
        if (requested_rate == '0)
            eff_rate = '0;                  // rate 0 never moves
        else if (rate_sum > {1'b0, RATE_MAX})
            eff_rate = RATE_MAX;
        else
            eff_rate = rate_sum[5:0];
        step    = {15'd0, 1'b1, eff_rate[1:0]} << eff_rate[5:2];
        acc_sum = {3'b000, acc[op_num]} + step;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc                   <= '{default: '0};
            rate_counter_overflow <= '0;
        end else if (sample_clk_en) begin
            acc[op_num] <= acc_sum[14:0];   // keep the remainder
            if (eff_rate >= ATTACK_INSTANT)
                rate_counter_overflow <= 3'd7;  // fastest rates
            else
                rate_counter_overflow <= acc_sum[17:15];    // carries past bit 15
        end
    end

endmodule

`default_nettype wire

// ==== design/env_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module env_top import op_reg_pkg::*, env_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            reg_wr,          // write strobe
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_data,
    input  wire op_num_t   op_num,          // from slot timing
    input  wire            sample_clk_en,
    output env_t           env
);

    op_regs_t op_regs;                      // slot operator's fields
    logic     dam;
    logic     key_on_pulse;
    logic     key_off_pulse;

    op_reg_file u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .op_num        (op_num),
        .sample_clk_en (sample_clk_en),
        .op_regs       (op_regs),
        .dam           (dam),
        .key_on_pulse  (key_on_pulse),
        .key_off_pulse (key_off_pulse)
    );

    envelope_generator u_env (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .op_num        (op_num),
        .op_regs       (op_regs),
        .dam           (dam),
        .key_on_pulse  (key_on_pulse),
        .key_off_pulse (key_off_pulse),
        .env           (env)
    );

endmodule

`default_nettype wire

// ==== design/envelope_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module envelope_generator import op_reg_pkg::*, env_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           sample_clk_en,
    input  wire op_num_t  op_num,
    input  wire op_regs_t op_regs,
    input  wire           dam,              // tremolo depth for the tremolo LFO
    input  wire           key_on_pulse,
    input  wire           key_off_pulse,
    output env_t          env
);

    env_state_t  state   [NUM_OPS];
    env_t        env_int [NUM_OPS];         // raw attenuation per op
    env_state_t  cur_state;
    env_state_t  next_state;
    env_t        cur_env;
    env_rate_t   requested_rate;
    overflow_t   rate_counter_overflow;
    ksl_add_t    ksl_add;
    am_val_t     am_val;
    logic        sample_d1;                 // slot cycle 1, attenuation update
    logic        instant;                   // attack fast enough to skip the curve
    logic [11:0] att_prod;
    env_t        att_dec;
    logic [9:0]  rise_sum;
    logic [10:0] env_tmp;

    ksl_add_rom u_ksl (
        .fnum    (op_regs.fnum),
        .block   (op_regs.block),
        .ksl     (op_regs.ksl),
        .ksl_add (ksl_add)
    );

    env_rate_counter u_rate (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .sample_clk_en         (sample_clk_en),
        .op_num                (op_num),
        .requested_rate        (requested_rate),
        .ksr                   (op_regs.ksr),
        .fnum                  (op_regs.fnum),
        .block                 (op_regs.block),
        .rate_counter_overflow (rate_counter_overflow)
    );

    tremolo u_trem (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .op_num        (op_num),
        .dam           (dam),
        .am_val        (am_val)
    );

    assign cur_state = state[op_num];
    assign cur_env   = env_int[op_num];

    always_comb begin
        next_state     = cur_state;
        requested_rate = '0;                // sustain holds
        case (cur_state)
            ATTACK: begin
                requested_rate = op_regs.ar;
                if (cur_env == '0)
                    next_state = DECAY;
            end
            DECAY: begin
                requested_rate = op_regs.dr;
                if (cur_env[8:4] >= {1'b0, op_regs.sl})
                    next_state = SUSTAIN;
            end
            SUSTAIN: begin
                if (!op_regs.egt)
                    next_state = RELEASE;
            end
            default: requested_rate = op_regs.rr;
        endcase
    end

    // key pulses beat the sample step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= '{default: RELEASE};
        else if (key_on_pulse)
            state[op_num] <= ATTACK;
        else if (key_off_pulse)
            state[op_num] <= RELEASE;
        else if (sample_clk_en)
            state[op_num] <= next_state;
    end

    always_comb begin
        instant  = {op_regs.ar, 2'b00} >= ATTACK_INSTANT;
        att_prod = {3'b000, cur_env} * {9'd0, rate_counter_overflow};
        att_dec  = att_prod[11:3] + 9'd1;   // exponential attack step
        rise_sum = {1'b0, cur_env} + {7'd0, rate_counter_overflow};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_d1 <= 1'b0;
            env_int   <= '{default: SILENCE};
        end else begin
            sample_d1 <= sample_clk_en;
            if (sample_d1) begin            // overflow is valid now
                if (cur_state == ATTACK && instant)
                    env_int[op_num] <= '0;
                else if (cur_state == ATTACK && rate_counter_overflow != '0 && cur_env != '0)
                    env_int[op_num] <= cur_env - att_dec;
                else if (cur_state == DECAY || cur_state == RELEASE)
                    env_int[op_num] <= (rise_sum > {1'b0, SILENCE}) ? SILENCE : rise_sum[8:0];
            end
        end
    end

    // total level, key scale and tremolo on top of the raw envelope
    always_comb begin
        env_tmp = {2'b00, cur_env} + {3'b000, op_regs.tl, 2'b00} + {3'b000, ksl_add};
        if (op_regs.am)
            env_tmp = env_tmp + {6'd0, am_val};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            env <= SILENCE;
        else
            env <= (env_tmp > {2'b00, SILENCE}) ? SILENCE : env_tmp[8:0];   // clip
    end

endmodule

`default_nettype wire

// ==== design/ksl_add_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module ksl_add_rom import op_reg_pkg::*, env_pkg::*; (
    input  wire fnum_t  fnum,
    input  wire block_t block,
    input  wire ksl_t   ksl,
    output ksl_add_t    ksl_add
);

    ksl_add_t base;                         // table value for top fnum bits
    ksl_add_t octave_sub;                   // 8 per octave below 7
    ksl_add_t floored;

    always_comb begin
        case (fnum[9:6])
            4'd0:  base = 8'd0;
            4'd1:  base = 8'd32;
            4'd2:  base = 8'd40;
            4'd3:  base = 8'd45;
            4'd4:  base = 8'd48;
            4'd5:  base = 8'd51;
            4'd6:  base = 8'd53;
            4'd7:  base = 8'd55;
            4'd8:  base = 8'd56;
            4'd9:  base = 8'd58;
            4'd10: base = 8'd59;
            4'd11: base = 8'd60;
            4'd12: base = 8'd61;
            4'd13: base = 8'd62;
            4'd14: base = 8'd63;
            default: base = 8'd64;
        endcase
    end

    always_comb begin
        octave_sub = {2'b00, 3'd7 - block, 3'b000};
        floored    = (base > octave_sub) ? base - octave_sub : '0;   // no negative attenuation
        case (ksl)
            2'd0:    ksl_add = '0;          // scaling off
            2'd1:    ksl_add = floored >> 1;
            2'd2:    ksl_add = floored >> 2;
            default: ksl_add = floored;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/op_reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module op_reg_file import op_reg_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            reg_wr,
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_data,
    input  wire op_num_t   op_num,          // slot operator
    input  wire            sample_clk_en,   // first cycle of slot
    output op_regs_t       op_regs,         // registers of the slot operator
    output logic           dam,             // tremolo depth
    output logic           key_on_pulse,
    output logic           key_off_pulse
);

    op_num_t              op_sel;           // operator targeted by writes
    op_regs_t             regs [NUM_OPS];
    logic [NUM_OPS-1:0]   pend_on;          // key-on waiting for its slot
    logic [NUM_OPS-1:0]   pend_off;         // key-off waiting for its slot

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_sel <= '0;
            dam    <= 1'b0;
            regs   <= '{default: '0};
        end else if (reg_wr) begin
            case (reg_addr)
                ADDR_OP_SEL: op_sel <= reg_data[1:0];
                ADDR_AR_DR: begin
                    regs[op_sel].ar <= reg_data[7:4];
                    regs[op_sel].dr <= reg_data[3:0];
                end
                ADDR_SL_RR: begin
                    regs[op_sel].sl <= reg_data[7:4];
                    regs[op_sel].rr <= reg_data[3:0];
                end
                ADDR_TL_KSL: begin
                    regs[op_sel].ksl <= reg_data[7:6];
                    regs[op_sel].tl  <= reg_data[5:0];
                end
                ADDR_FLAGS: begin
                    regs[op_sel].am  <= reg_data[2];
                    regs[op_sel].egt <= reg_data[1];
                    regs[op_sel].ksr <= reg_data[0];
                end
                ADDR_FNUM_LO: regs[op_sel].fnum[7:0] <= reg_data;
                ADDR_FNUM_HI_BLK: begin
                    regs[op_sel].fnum[9:8] <= reg_data[1:0];
                    regs[op_sel].block     <= reg_data[4:2];
                end
                ADDR_GLOBAL: dam <= reg_data[0];
                default: ;                  // key writes handled below
            endcase
        end
    end

    // pending key requests, consumed at the op's next slot start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_on  <= '0;
            pend_off <= '0;
        end else begin
            if (sample_clk_en) begin        // pulse goes out this cycle
                pend_on[op_num]  <= 1'b0;
                pend_off[op_num] <= 1'b0;
            end
            if (reg_wr && reg_addr == ADDR_KEY) begin   // new write beats the clear
                if (reg_data[0])
                    pend_on[op_sel] <= 1'b1;
                if (reg_data[1])
                    pend_off[op_sel] <= 1'b1;
            end
        end
    end

    assign op_regs       = regs[op_num];
    assign key_on_pulse  = sample_clk_en && pend_on[op_num];
    assign key_off_pulse = sample_clk_en && pend_off[op_num] && !pend_on[op_num];  // on wins

endmodule

`default_nettype wire

// ==== design/op_reg_pkg.sv ====
`default_nettype none

package op_reg_pkg;

    localparam int NUM_OPS = 4;             // operators in the bank

    typedef logic [1:0] op_num_t;           // operator index
    typedef logic [3:0] reg_addr_t;         // register bus address
    typedef logic [7:0] reg_data_t;         // register bus write data

    // register map
    localparam reg_addr_t ADDR_OP_SEL      = 4'd0;  // target operator for later writes
    localparam reg_addr_t ADDR_AR_DR       = 4'd1;  // ar 7:4, dr 3:0
    localparam reg_addr_t ADDR_SL_RR       = 4'd2;  // sl 7:4, rr 3:0
    localparam reg_addr_t ADDR_TL_KSL      = 4'd3;  // ksl 7:6, tl 5:0
    localparam reg_addr_t ADDR_FLAGS       = 4'd4;  // am 2, egt 1, ksr 0
    localparam reg_addr_t ADDR_FNUM_LO     = 4'd5;  // fnum 7:0
    localparam reg_addr_t ADDR_FNUM_HI_BLK = 4'd6;  // block 4:2, fnum 9:8 in 1:0
    localparam reg_addr_t ADDR_KEY         = 4'd7;  // key-on 0, key-off 1
    localparam reg_addr_t ADDR_GLOBAL      = 4'd8;  // dam 0, shared by all ops

    // register field widths
    typedef logic [3:0] env_rate_t;         // ar/dr/sl/rr nibble
    typedef logic [5:0] tl_t;               // total level, 0.75 dB steps
    typedef logic [1:0] ksl_t;              // key scale level select
    typedef logic [9:0] fnum_t;             // frequency number
    typedef logic [2:0] block_t;            // octave

    typedef struct packed {
        env_rate_t ar;                      // attack rate
        env_rate_t dr;                      // decay rate
        env_rate_t sl;                      // sustain level
        env_rate_t rr;                      // release rate
        tl_t       tl;
        ksl_t      ksl;
        logic      am;                      // tremolo enable
        logic      egt;                     // hold at sustain while set
        logic      ksr;                     // key scale rate
        fnum_t     fnum;
        block_t    block;
    } op_regs_t;

endpackage

`default_nettype wire

// ==== design/tremolo.sv ====
`timescale 1ns/1ns
`default_nettype none

module tremolo import op_reg_pkg::*, env_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          sample_clk_en,
    input  wire op_num_t op_num,
    input  wire          dam,               // 1 = deep tremolo
    output am_val_t      am_val
);

    logic [11:0] cnt;                       // shared LFO counter
    logic [5:0]  pos;                       // 0..TREM_TOP
    logic [5:0]  tri_pos;                   // 0..TREM_PEAK..1

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (sample_clk_en && op_num == '0) begin   // once per sample frame
            if (cnt == {TREM_TOP, 6'h3f})
                cnt <= '0;
            else
                cnt <= cnt + 12'd1;
        end
    end

    always_comb begin
        pos     = cnt[11:6];
        tri_pos = (pos <= TREM_PEAK) ? pos : TREM_TOP + 6'd1 - pos;    // fold back down
        am_val  = dam ? tri_pos[4:0] : 5'(tri_pos[4:2]);
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the envelope testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module env_tb -o env_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/env_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0

// ==== verification/env_model.svh ====
`ifndef ENV_MODEL_SVH
`define ENV_MODEL_SVH

// ksl base attenuation by fnum[9:6]
localparam int KSL_BASE [16] = '{0, 32, 40, 45, 48, 51, 53, 55, 56, 58, 59, 60, 61, 62, 63, 64};

function automatic int ksl_model(input fnum_t f, input block_t b, input ksl_t k);
    int sub;
    int v;
    sub = 8 * (7 - int'(b));                // 8 per octave below the top
    v   = (KSL_BASE[f[9:6]] > sub) ? KSL_BASE[f[9:6]] - sub : 0;
    case (k)
        2'd0:    return 0;
        2'd1:    return v / 2;
        2'd2:    return v / 4;
        default: return v;
    endcase
endfunction

function automatic int eff_rate_model(input int rate, input logic ksr, input fnum_t f,
                                      input block_t b);
    int rof;
    int x;
    if (rate == 0)
        return 0;                           // rate 0 is frozen
    rof = ksr ? int'(b) * 2 + int'(f[9]) : int'(b) / 4;
    x   = 4 * rate + rof;
    return (x > 63) ? 63 : x;
endfunction

// attenuation after one sample, state already updated
function automatic int env_next_model(input env_state_t s, input int e, input int ov,
                                      input env_rate_t ar);
    if (s == ATTACK && int'(ar) * 4 >= 60)
        return 0;                           // instant attack
    if (s == ATTACK && ov != 0 && e != 0)
        return e - ((e * ov) / 8 + 1);
    if (s == DECAY || s == RELEASE)
        return (e + ov > 511) ? 511 : e + ov;
    return e;
endfunction

function automatic int am_model(input int cnt, input logic deep);
    int pos;
    int tri_pos;
    pos     = cnt / 64;
    tri_pos = (pos <= 26) ? pos : 52 - pos; // up to the peak and back
    return deep ? tri_pos : tri_pos / 4;
endfunction

`endif

// ==== verification/env_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module env_tb import op_reg_pkg::*, env_pkg::*; ();

    `include "env_model.svh"

    localparam int FRAMES      = 3559;     // slot frames run by all tests
    localparam int WRITES      = 100;      // register writes, upper bound
    localparam int TEST_CYCLES = 8 + FRAMES * 16 + WRITES * 2;

    logic       clk;
    logic       rst_n;
    logic       reg_wr;
    reg_addr_t  reg_addr;
    reg_data_t  reg_data;
    op_num_t    op_num;
    logic       sample_clk_en;
    env_t       env;

    op_regs_t   m_regs  [NUM_OPS];         // model copy of the register file
    env_state_t m_state [NUM_OPS];
    int         m_env   [NUM_OPS];
    int         m_acc   [NUM_OPS];
    bit         m_on    [NUM_OPS];         // pending key requests
    bit         m_off   [NUM_OPS];
    int         m_cnt;                     // tremolo counter
    logic       m_dam;
    logic [15:0] lfsr = 16'd77;

    env_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .op_num        (op_num),
        .sample_clk_en (sample_clk_en),
        .env           (env)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 2 * 10);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // taps 16,14,13,11
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic op_regs_t rand_regs();
        op_regs_t r;
        r       = '0;
        r.tl    = tl_t'(rand_bits(6));
        r.ksl   = ksl_t'(rand_bits(2));
        r.fnum  = fnum_t'(rand_bits(10));
        r.block = block_t'(rand_bits(3));
        r.ksr   = rand_bits(1) != 0;
        r.sl    = env_rate_t'(rand_bits(4));
        r.rr    = env_rate_t'(rand_bits(4));
        return r;
    endfunction

    // expected env of op k for this slot, advances the model
    function automatic env_t model_slot(input int k);
        op_regs_t   r;
        env_state_t s;
        int         e;
        int         rate;
        int         eff;
        int         sum;
        int         ov;
        int         out;
        r = m_regs[k];
        s = m_state[k];
        e = m_env[k];
        case (s)
            ATTACK:  rate = int'(r.ar);
            DECAY:   rate = int'(r.dr);
            SUSTAIN: rate = 0;
            default: rate = int'(r.rr);
        endcase
        eff      = eff_rate_model(rate, r.ksr, r.fnum, r.block);  // rate of the old state
        sum      = m_acc[k] + ((4 + eff % 4) << (eff / 4));
        ov       = (eff >= 60) ? 7 : (((sum >> 15) > 7) ? 7 : sum >> 15);
        m_acc[k] = sum % 32768;
        if (m_on[k])
            s = ATTACK;                     // key-on beats key-off
        else if (m_off[k])
            s = RELEASE;
        else if (s == ATTACK && e == 0)
            s = DECAY;
        else if (s == DECAY && e / 16 >= int'(r.sl))
            s = SUSTAIN;
        else if (s == SUSTAIN && !r.egt)
            s = RELEASE;
        m_on[k]    = 1'b0;
        m_off[k]   = 1'b0;
        e          = env_next_model(s, e, ov, r.ar);
        m_state[k] = s;
        m_env[k]   = e;
        if (k == 0)
            m_cnt = (m_cnt == 3327) ? 0 : m_cnt + 1;
        out = e + 4 * int'(r.tl) + ksl_model(r.fnum, r.block, r.ksl);
        if (r.am)
            out = out + am_model(m_cnt, m_dam);
        return env_t'((out > 511) ? 511 : out);
    endfunction

    task automatic check_env(input env_t expected, input env_t actual);
        if (actual !== expected) begin
            $display("ERR t=%0t env expected=%0d actual=%0d", $time, expected, actual);
            $display("Simulation failed");
            $fatal(1, "env mismatch");
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(negedge clk);
        reg_wr   = 1'b1;
        reg_addr = a;
        reg_data = d;
        @(negedge clk);
        reg_wr   = 1'b0;
    endtask

    task automatic program_op(input int k, input op_regs_t r);
        write_reg(ADDR_OP_SEL, reg_data_t'(k));
        write_reg(ADDR_AR_DR, {r.ar, r.dr});
        write_reg(ADDR_SL_RR, {r.sl, r.rr});
        write_reg(ADDR_TL_KSL, {r.ksl, r.tl});
        write_reg(ADDR_FLAGS, {5'd0, r.am, r.egt, r.ksr});
        write_reg(ADDR_FNUM_LO, r.fnum[7:0]);
        write_reg(ADDR_FNUM_HI_BLK, {3'd0, r.block, r.fnum[9:8]});
        m_regs[k] = r;
    endtask

    task automatic key(input int k, input logic on, input logic off);
        write_reg(ADDR_OP_SEL, reg_data_t'(k));
        write_reg(ADDR_KEY, {6'd0, off, on});
        m_on[k]  = m_on[k] | on;            // pulse waits for the op's slot
        m_off[k] = m_off[k] | off;
    endtask

    task automatic set_dam(input logic d);
        write_reg(ADDR_GLOBAL, {7'd0, d});
        m_dam = d;
    endtask

    // env valid from slot cycle 3
    task automatic run_slot(input int k);
        env_t expected;
        @(negedge clk);
        op_num        = op_num_t'(k);
        sample_clk_en = 1'b1;
        expected      = model_slot(k);
        @(negedge clk);
        sample_clk_en = 1'b0;
        repeat (2) @(negedge clk);
        check_env(expected, env);
    endtask

    task automatic run_frames(input int n);
        for (int f = 0; f < n; f++)
            for (int k = 0; k < NUM_OPS; k++)
                run_slot(k);
    endtask

    task automatic test_reset();
        run_frames(1);                      // all ops silent
    endtask

    task automatic test_attack();
        op_regs_t r;
        for (int k = 0; k < NUM_OPS; k++) begin
            r     = rand_regs();
            r.ar  = 4'd15;                  // instant attack
            r.dr  = 4'd0;
            r.egt = 1'b1;
            program_op(k, r);
            key(k, 1'b1, 1'b0);
        end
        run_frames(2);
    endtask

    task automatic test_decay();
        op_regs_t r;
        r     = rand_regs();
        r.ar  = 4'd15;
        r.dr  = env_rate_t'(14 + rand_bits(1));
        r.sl  = env_rate_t'(rand_bits(3));  // low sustain so it settles in time
        r.egt = 1'b1;
        program_op(1, r);
        key(1, 1'b1, 1'b0);
        run_frames(64);
    endtask

    task automatic test_release();
        op_regs_t r;
        r     = m_regs[1];
        r.egt = 1'b0;                       // sustain drops into release
        r.rr  = 4'd15;
        program_op(1, r);
        r     = m_regs[2];
        r.rr  = 4'd15;
        program_op(2, r);
        key(2, 1'b0, 1'b1);
        run_frames(80);
    endtask

    task automatic test_tremolo();
        op_regs_t r;
        r     = '0;
        r.ar  = 4'd15;
        r.egt = 1'b1;
        r.am  = 1'b1;
        program_op(0, r);
        r.am  = 1'b0;
        program_op(3, r);
        key(0, 1'b1, 1'b0);
        key(3, 1'b1, 1'b0);
        set_dam(1'b1);
        run_frames(1700);                   // past the triangle peak
        set_dam(1'b0);                      // shallow depth
        run_frames(1700);                   // through the counter wrap
    endtask

    task automatic test_restart();
        op_regs_t r;
        r    = m_regs[1];
        r.ar = 4'd12;                       // slow attack curve from silence
        program_op(1, r);
        key(1, 1'b1, 1'b0);                 // op 1 sits in release here
        run_frames(12);
    endtask

    initial begin
        rst_n         = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_data      = '0;
        op_num        = '0;
        sample_clk_en = 1'b0;
        m_cnt         = 0;
        m_dam         = 1'b0;
        for (int k = 0; k < NUM_OPS; k++) begin
            m_regs[k]  = '0;
            m_state[k] = RELEASE;
            m_env[k]   = 511;
            m_acc[k]   = 0;
            m_on[k]    = 1'b0;
            m_off[k]   = 1'b0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_attack();
        test_decay();
        test_release();
        test_tremolo();
        test_restart();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
design/op_reg_pkg.sv
design/env_pkg.sv
design/op_reg_file.sv
design/ksl_add_rom.sv
design/env_rate_counter.sv
design/tremolo.sv
design/envelope_generator.sv
design/env_top.sv
verification/env_tb.sv
